// File: logic/fetch_pkg.sv
package fetch_pkg;

  // address and pc width
  localparam int PC_W = 64;

  // one rv instruction
  localparam int INST_W = 32;

  // addi x0, x0, 0
  // sent whenever decode gets no fetched word
  localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013;

  // config register map
  localparam logic [1:0] CFG_BOOT_PC  = 2'd0;
  localparam logic [1:0] CFG_FETCH_EN = 2'd1;
  localparam logic [1:0] CFG_WAIT     = 2'd2;

endpackage

// File: logic/axi_rd_pkg.sv
package axi_rd_pkg;

  // id and data width on ar/r
  localparam int ID_W   = 4;
  localparam int DATA_W = 64;

  // requester tags
  localparam logic [ID_W-1:0] ID_IF  = 4'd0;
  localparam logic [ID_W-1:0] ID_MEM = 4'd1;

  // normal access response
  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// File: logic/fetch_ctrl_regs.sv
module fetch_ctrl_regs
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            cfg_we_i,
  input  logic [1:0]      cfg_addr_i,
  input  logic [PC_W-1:0] cfg_wdata_i,
  output logic [PC_W-1:0] boot_pc_o,
  output logic            fetch_en_o,
  output logic [3:0]      wait_cycles_o
);

  // write strobes per register
  logic we_boot;
  logic we_en;
  logic we_wait;

  assign we_boot = cfg_we_i && (cfg_addr_i == CFG_BOOT_PC);
  assign we_en   = cfg_we_i && (cfg_addr_i == CFG_FETCH_EN);
  assign we_wait = cfg_we_i && (cfg_addr_i == CFG_WAIT);

  // new values visible the cycle after the write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      boot_pc_o     <= '0;
      fetch_en_o    <= 1'b0;
      // one wait state out of reset
      wait_cycles_o <= 4'd1;
    end else begin
      if (we_boot) begin
        boot_pc_o <= cfg_wdata_i;
      end
      // only bit 0 matters for enable
      if (we_en) begin
        fetch_en_o <= cfg_wdata_i[0];
      end
      if (we_wait) begin
        wait_cycles_o <= cfg_wdata_i[3:0];
      end
    end
  end

endmodule

// File: logic/pc_gen.sv
module pc_gen
  import fetch_pkg::*;
  import axi_rd_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [PC_W-1:0]   boot_pc_i,
  input  logic              fetch_en_i,
  input  logic              redirect_i,
  input  logic [PC_W-1:0]   redirect_pc_i,
  input  logic              stall_i,
  output logic              if_req_o,
  output logic [PC_W-1:0]   if_addr_o,
  input  logic              if_done_i,
  input  logic [DATA_W-1:0] if_data_i,
  output logic [INST_W-1:0] inst_o,
  output logic [PC_W-1:0]   inst_pc_o,
  output logic              inst_valid_o
);

  logic              fetch_en_q;
  logic [PC_W-1:0]   pc_q;
  logic              pending_q;
  logic [PC_W-1:0]   addr_q;
  logic              discard_q;
  logic              word_valid_q;
  logic [INST_W-1:0] word_q;
  logic [PC_W-1:0]   word_pc_q;
  logic              load_boot;
  logic              flush;
  logic              keep;
  logic              start;
  logic [INST_W-1:0] half;

  // enable 0 -> 1 reloads the boot pc
  assign load_boot = fetch_en_i && !fetch_en_q;
  // either redirect or reboot kills what is in flight
  assign flush = redirect_i || load_boot;
  // answer worth keeping
  assign keep = if_done_i && !discard_q && !flush;
  // one fetch at a time, none while stalled or on a pc change
  assign start = fetch_en_i && fetch_en_q && !stall_i && !pending_q && !redirect_i;

  // bit 2 of the fetch address picks the half of the doubleword
  assign half = addr_q[2] ? if_data_i[DATA_W-1:INST_W] : if_data_i[INST_W-1:0];

  assign if_req_o  = pending_q;
  assign if_addr_o = addr_q;

  // held word goes out on the first unstalled cycle
  assign inst_valid_o = word_valid_q && !stall_i;
  assign inst_o       = inst_valid_o ? word_q : NOP_INST;
  assign inst_pc_o    = word_pc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q   <= 1'b0;
      pc_q         <= '0;
      pending_q    <= 1'b0;
      addr_q       <= '0;
      discard_q    <= 1'b0;
      word_valid_q <= 1'b0;
    end else begin
      fetch_en_q <= fetch_en_i;
      // pc sequencing
      if (load_boot) begin
        pc_q <= boot_pc_i;
      end else if (redirect_i) begin
        pc_q <= redirect_pc_i;
      end else if (keep) begin
        pc_q <= pc_q + PC_W'(4);
      end
      // request held until done
      if (start) begin
        pending_q <= 1'b1;
        addr_q    <= pc_q;
      end else if (if_done_i) begin
        pending_q <= 1'b0;
      end
      // mark a stale fetch, its answer is dropped
      if (if_done_i) begin
        discard_q <= 1'b0;
      end else if (flush && pending_q) begin
        discard_q <= 1'b1;
      end
      // word flag, set on keep, cleared once presented
      if (flush) begin
        word_valid_q <= 1'b0;
      end else if (keep) begin
        word_valid_q <= 1'b1;
      end else if (inst_valid_o) begin
        word_valid_q <= 1'b0;
      end
    end
  end

  // returned word, like a delayed r_done capture
  always_ff @(posedge clk) begin
    if (keep) begin
      word_q    <= half;
      word_pc_q <= addr_q;
    end
  end

endmodule

// File: logic/rd_arbiter.sv
module rd_arbiter
  import fetch_pkg::*;
  import axi_rd_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              if_req_i,
  input  logic [PC_W-1:0]   if_addr_i,
  output logic              if_done_o,
  input  logic              mem_valid_i,
  input  logic [PC_W-1:0]   mem_addr_i,
  output logic              mem_done_o,
  output logic [DATA_W-1:0] mem_rdata_o,
  output logic              rd_valid_o,
  output logic [ID_W-1:0]   rd_id_o,
  output logic [PC_W-1:0]   rd_addr_o,
  input  logic              rd_done_i,
  input  logic [ID_W-1:0]   rd_rid_i,
  input  logic [DATA_W-1:0] rd_data_i
);

  logic            busy_q;
  logic            mem_pend_q;
  logic [PC_W-1:0] mem_addr_q;
  logic            mem_req;
  logic [PC_W-1:0] mem_addr_sel;
  logic            grant;

  // mem stage pulse, live or latched
  assign mem_req      = mem_pend_q || mem_valid_i;
  assign mem_addr_sel = mem_pend_q ? mem_addr_q : mem_addr_i;
  // one read in flight
  assign grant = !busy_q && (mem_req || if_req_i);

  // route completion back by id
  assign if_done_o   = rd_done_i && (rd_rid_i == ID_IF);
  assign mem_done_o  = rd_done_i && (rd_rid_i == ID_MEM);
  assign mem_rdata_o = rd_data_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q     <= 1'b0;
      mem_pend_q <= 1'b0;
      rd_valid_o <= 1'b0;
    end else begin
      // single-cycle issue pulse
      rd_valid_o <= grant;
      if (grant) begin
        busy_q <= 1'b1;
      end else if (rd_done_i) begin
        busy_q <= 1'b0;
      end
      // keep the pulse until it is served
      if (grant && mem_req) begin
        mem_pend_q <= 1'b0;
      end else if (mem_valid_i) begin
        mem_pend_q <= 1'b1;
      end
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (mem_valid_i) begin
      mem_addr_q <= mem_addr_i;
    end
    // mem stage wins a tie
    if (grant) begin
      rd_id_o   <= mem_req ? ID_MEM : ID_IF;
      rd_addr_o <= mem_req ? mem_addr_sel : if_addr_i;
    end
  end

endmodule

// File: logic/axi_rd_master.sv
module axi_rd_master
  import fetch_pkg::*;
  import axi_rd_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rd_valid_i,
  input  logic [ID_W-1:0]   rd_id_i,
  input  logic [PC_W-1:0]   rd_addr_i,
  output logic              rd_done_o,
  output logic [ID_W-1:0]   rd_rid_o,
  output logic [DATA_W-1:0] rd_data_o,
  output logic              ar_valid_o,
  input  logic              ar_ready_i,
  output logic [PC_W-1:0]   ar_addr_o,
  output logic [ID_W-1:0]   ar_id_o,
  input  logic              r_valid_i,
  output logic              r_ready_o,
  input  logic [DATA_W-1:0] r_data_i,
  input  logic [1:0]        r_resp_i,
  input  logic              r_last_i,
  input  logic [ID_W-1:0]   r_id_i
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_ADDR = 2'd1;
  localparam logic [1:0] S_DATA = 2'd2;

  logic [1:0]      state_q;
  logic [PC_W-1:0] addr_q;
  logic [ID_W-1:0] id_q;
  logic            ar_hs;
  logic            r_hs;
  logic            r_end;

  // ar valid straight from the state, stays up until ready
  assign ar_valid_o = (state_q == S_ADDR);
  assign ar_addr_o  = addr_q;
  assign ar_id_o    = id_q;
  // always willing to take the beat
  assign r_ready_o  = 1'b1;

  assign ar_hs = ar_valid_o && ar_ready_i;
  assign r_hs  = (state_q == S_DATA) && r_valid_i && r_ready_o;
  // last beat ends it, an error response ends it too
  assign r_end = r_hs && (r_last_i || (r_resp_i != RESP_OKAY));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= S_IDLE;
      rd_done_o <= 1'b0;
    end else begin
      // done one cycle after the r beat
      rd_done_o <= r_end;
      case (state_q)
        S_IDLE: begin
          if (rd_valid_i) begin
            state_q <= S_ADDR;
          end
        end
        S_ADDR: begin
          if (ar_hs) begin
            state_q <= S_DATA;
          end
        end
        S_DATA: begin
          if (r_end) begin
            state_q <= S_IDLE;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // request and response payload
  always_ff @(posedge clk) begin
    if ((state_q == S_IDLE) && rd_valid_i) begin
      addr_q <= rd_addr_i;
      id_q   <= rd_id_i;
    end
    // data passes through whatever the resp code
    if (r_end) begin
      rd_data_o <= r_data_i;
      rd_rid_o  <= r_id_i;
    end
  end

endmodule

// File: logic/axi_rd_mem.sv
module axi_rd_mem
  import fetch_pkg::*;
  import axi_rd_pkg::*;
#(
  parameter int MEM_WORDS = 256,
  parameter int MAX_WAIT  = 15
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [3:0]        wait_cycles_i,
  input  logic              ld_we_i,
  input  logic [PC_W-1:0]   ld_addr_i,
  input  logic [DATA_W-1:0] ld_wdata_i,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  logic [PC_W-1:0]   ar_addr_i,
  input  logic [ID_W-1:0]   ar_id_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output logic [DATA_W-1:0] r_data_o,
  output logic [1:0]        r_resp_o,
  output logic              r_last_o,
  output logic [ID_W-1:0]   r_id_o
);

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int CNT_W = $clog2(MAX_WAIT + 1);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_WAIT = 2'd1;
  localparam logic [1:0] S_RESP = 2'd2;

  logic [DATA_W-1:0] mem_q [MEM_WORDS];
  logic [1:0]        state_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [IDX_W-1:0]  idx_q;
  logic [ID_W-1:0]   id_q;
  logic [CNT_W-1:0]  wait_ld;
  logic              ar_hs;

  // clamp wait states to the counter range
  assign wait_ld = (int'(wait_cycles_i) > MAX_WAIT) ? CNT_W'(MAX_WAIT) : CNT_W'(wait_cycles_i);

  assign ar_ready_o = (state_q == S_IDLE);
  assign ar_hs      = ar_valid_i && ar_ready_o;

  // single beat, always okay
  assign r_valid_o = (state_q == S_RESP);
  assign r_data_o  = mem_q[idx_q];
  assign r_resp_o  = RESP_OKAY;
  assign r_last_o  = 1'b1;
  assign r_id_o    = id_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          // zero wait goes straight to the beat
          if (ar_hs) begin
            cnt_q   <= wait_ld;
            state_q <= (wait_ld == '0) ? S_RESP : S_WAIT;
          end
        end
        S_WAIT: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == CNT_W'(1)) begin
            state_q <= S_RESP;
          end
        end
        S_RESP: begin
          if (r_ready_i) begin
            state_q <= S_IDLE;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // doubleword index from byte address, plus boot load port
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      idx_q <= ar_addr_i[IDX_W+2:3];
      id_q  <= ar_id_i;
    end
    if (ld_we_i) begin
      mem_q[ld_addr_i[IDX_W+2:3]] <= ld_wdata_i;
    end
  end

endmodule

// File: logic/if_stage_top.sv
module if_stage_top
  import fetch_pkg::*;
  import axi_rd_pkg::*;
#(
  parameter int MEM_WORDS = 256,
  parameter int MAX_WAIT  = 15
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cfg_we_i,
  input  logic [1:0]        cfg_addr_i,
  input  logic [PC_W-1:0]   cfg_wdata_i,
  input  logic              ld_we_i,
  input  logic [PC_W-1:0]   ld_addr_i,
  input  logic [DATA_W-1:0] ld_wdata_i,
  input  logic              redirect_i,
  input  logic [PC_W-1:0]   redirect_pc_i,
  input  logic              stall_i,
  output logic [INST_W-1:0] inst_o,
  output logic [PC_W-1:0]   inst_pc_o,
  output logic              inst_valid_o,
  input  logic              mem_valid_i,
  input  logic [PC_W-1:0]   mem_addr_i,
  output logic              mem_done_o,
  output logic [DATA_W-1:0] mem_rdata_o
);

  // config
  logic [PC_W-1:0]   boot_pc;
  logic              fetch_en;
  logic [3:0]        wait_cycles;
  // fetch request
  logic              if_req;
  logic [PC_W-1:0]   if_addr;
  logic              if_done;
  // arbiter to master
  logic              rd_valid;
  logic [ID_W-1:0]   rd_id;
  logic [PC_W-1:0]   rd_addr;
  logic              rd_done;
  logic [ID_W-1:0]   rd_rid;
  logic [DATA_W-1:0] rd_data;
  // ar/r between master and memory
  logic              ar_valid;
  logic              ar_ready;
  logic [PC_W-1:0]   ar_addr;
  logic [ID_W-1:0]   ar_id;
  logic              r_valid;
  logic              r_ready;
  logic [DATA_W-1:0] r_data;
  logic [1:0]        r_resp;
  logic              r_last;
  logic [ID_W-1:0]   r_id;

  fetch_ctrl_regs u_regs (
    .clk(clk), .rst_n(rst_n),
    .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i), .cfg_wdata_i(cfg_wdata_i),
    .boot_pc_o(boot_pc), .fetch_en_o(fetch_en), .wait_cycles_o(wait_cycles)
  );

  pc_gen u_pc_gen (
    .clk(clk), .rst_n(rst_n),
    .boot_pc_i(boot_pc), .fetch_en_i(fetch_en),
    .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i), .stall_i(stall_i),
    .if_req_o(if_req), .if_addr_o(if_addr), .if_done_i(if_done), .if_data_i(rd_data),
    .inst_o(inst_o), .inst_pc_o(inst_pc_o), .inst_valid_o(inst_valid_o)
  );

  rd_arbiter u_arb (
    .clk(clk), .rst_n(rst_n),
    .if_req_i(if_req), .if_addr_i(if_addr), .if_done_o(if_done),
    .mem_valid_i(mem_valid_i), .mem_addr_i(mem_addr_i),
    .mem_done_o(mem_done_o), .mem_rdata_o(mem_rdata_o),
    .rd_valid_o(rd_valid), .rd_id_o(rd_id), .rd_addr_o(rd_addr),
    .rd_done_i(rd_done), .rd_rid_i(rd_rid), .rd_data_i(rd_data)
  );

  axi_rd_master u_axi_master (
    .clk(clk), .rst_n(rst_n),
    .rd_valid_i(rd_valid), .rd_id_i(rd_id), .rd_addr_i(rd_addr),
    .rd_done_o(rd_done), .rd_rid_o(rd_rid), .rd_data_o(rd_data),
    .ar_valid_o(ar_valid), .ar_ready_i(ar_ready), .ar_addr_o(ar_addr), .ar_id_o(ar_id),
    .r_valid_i(r_valid), .r_ready_o(r_ready), .r_data_i(r_data),
    .r_resp_i(r_resp), .r_last_i(r_last), .r_id_i(r_id)
  );

  axi_rd_mem #(
    .MEM_WORDS(MEM_WORDS),
    .MAX_WAIT(MAX_WAIT)
  ) u_axi_mem (
    .clk(clk), .rst_n(rst_n), .wait_cycles_i(wait_cycles),
    .ld_we_i(ld_we_i), .ld_addr_i(ld_addr_i), .ld_wdata_i(ld_wdata_i),
    .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_addr_i(ar_addr), .ar_id_i(ar_id),
    .r_valid_o(r_valid), .r_ready_i(r_ready), .r_data_o(r_data),
    .r_resp_o(r_resp), .r_last_o(r_last), .r_id_o(r_id)
  );

endmodule

// File: tests/if_stage_assert.sv
module if_stage_assert (
  input logic clk,
  input logic rst_n,
  input logic ar_valid_i,
  input logic ar_ready_i,
  input logic r_valid_i,
  input logic r_ready_i,
  input logic r_last_i,
  input logic rd_valid_i,
  input logic rd_done_i
);

  // one read open from issue until done
  logic busy_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (rd_valid_i) begin
      busy_q <= 1'b1;
    end else if (rd_done_i) begin
      busy_q <= 1'b0;
    end
  end

  // ar valid stays up until the slave takes it
  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_i && !ar_ready_i |=> ar_valid_i)
    else $error("ar_valid dropped before ar_ready");

  // single beat reads only
  r_single: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid_i && r_ready_i |-> r_last_i)
    else $error("r beat without r_last");

  no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid_i |-> !busy_q)
    else $error("second read issued before rd_done");

endmodule

bind axi_rd_master if_stage_assert u_master_chk (
  .clk(clk), .rst_n(rst_n),
  .ar_valid_i(ar_valid_o), .ar_ready_i(ar_ready_i),
  .r_valid_i(r_valid_i), .r_ready_i(r_ready_o), .r_last_i(r_last_i),
  .rd_valid_i(rd_valid_i), .rd_done_i(rd_done_o)
);

// memory side, a read runs from the ar transfer to the r beat
bind axi_rd_mem if_stage_assert u_mem_chk (
  .clk(clk), .rst_n(rst_n),
  .ar_valid_i(ar_valid_i), .ar_ready_i(ar_ready_o),
  .r_valid_i(r_valid_o), .r_ready_i(r_ready_i), .r_last_i(r_last_o),
  .rd_valid_i(ar_valid_i && ar_ready_o), .rd_done_i(r_valid_o && r_ready_i)
);

// File: tests/tb_if_stage.sv
module tb_if_stage
  import fetch_pkg::*;
  import axi_rd_pkg::*;
();

  logic              clk;
  logic              rst_n;
  logic              cfg_we;
  logic [1:0]        cfg_addr;
  logic [PC_W-1:0]   cfg_wdata;
  logic              ld_we;
  logic [PC_W-1:0]   ld_addr;
  logic [DATA_W-1:0] ld_wdata;
  logic              redirect;
  logic [PC_W-1:0]   redirect_pc;
  logic              stall;
  logic [INST_W-1:0] inst;
  logic [PC_W-1:0]   inst_pc;
  logic              inst_valid;
  logic              mem_valid;
  logic [PC_W-1:0]   mem_addr;
  logic              mem_done;
  logic [DATA_W-1:0] mem_rdata;

  // parsed records
  string       kind_q[$];
  string       name_q[$];
  logic [63:0] a_q[$];
  logic [63:0] b_q[$];
  // words seen on the fetch output
  logic [PC_W-1:0]   seen_pc[$];
  logic [INST_W-1:0] seen_inst[$];

  string       cur_name;
  int          errors;
  int          test_err;
  int          checks;
  int          tests;
  int          done_cnt;
  logic [63:0] done_data;
  int          limit;
  int          cycles;
  logic        limit_set;

  if_stage_top #(.MEM_WORDS(256), .MAX_WAIT(15)) dut0 (
    .clk(clk), .rst_n(rst_n),
    .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata),
    .ld_we_i(ld_we), .ld_addr_i(ld_addr), .ld_wdata_i(ld_wdata),
    .redirect_i(redirect), .redirect_pc_i(redirect_pc), .stall_i(stall),
    .inst_o(inst), .inst_pc_o(inst_pc), .inst_valid_o(inst_valid),
    .mem_valid_i(mem_valid), .mem_addr_i(mem_addr),
    .mem_done_o(mem_done), .mem_rdata_o(mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // watchdog, limit comes from the test lengths
  initial begin
    cycles = 0;
    wait (limit_set);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped: no progress within %0d cycles", limit);
    $display("Simulation failed");
    $finish;
  end

  function automatic bit read_records();
    int          fd;
    int          rc;
    string       k;
    string       nm;
    string       rest;
    logic [63:0] a;
    logic [63:0] b;
    fd = $fopen("tests/fetch_input.txt", "r");
    if (fd == 0) begin
      return 1'b0;
    end
    while (!$feof(fd)) begin
      rc = $fscanf(fd, "%s", k);
      if (rc != 1) break;
      nm = "";
      a = '0;
      b = '0;
      if (k == "#") begin
        rc = $fgets(rest, fd);
        continue;
      end else if (k == "T") begin
        rc = $fscanf(fd, "%s %d", nm, a);
      end else if (k != "S") begin
        rc = $fscanf(fd, "%h %h", a, b);
      end
      kind_q.push_back(k);
      name_q.push_back(nm);
      a_q.push_back(a);
      b_q.push_back(b);
    end
    $fclose(fd);
    return 1'b1;
  endfunction

  function automatic void count_error();
    errors++;
    test_err++;
  endfunction

  // sample after the inputs driven on this falling edge settle
  // then move on to the next falling edge
  task automatic step();
    #1;
    if (inst_valid) begin
      seen_pc.push_back(inst_pc);
      seen_inst.push_back(inst);
    end else begin
      assert (inst === NOP_INST) else begin
        $display("[ERROR] %s: bubble expected %h actual %h", cur_name, NOP_INST, inst);
        count_error();
      end
    end
    if (stall) begin
      assert (!inst_valid) else begin
        $display("%s: instruction presented while stalled", cur_name);
        count_error();
      end
    end
    if (mem_done) begin
      done_cnt++;
      done_data = mem_rdata;
    end
    @(negedge clk);
  endtask

  task automatic close_test();
    if (tests > 0) begin
      $display("test %s: checks %0d, errors %0d", cur_name, checks, test_err);
    end
  endtask

  task automatic expect_inst(logic [63:0] pc, logic [63:0] word);
    logic [PC_W-1:0]   got_pc;
    logic [INST_W-1:0] got_inst;
    while (seen_pc.size() == 0) step();
    got_pc = seen_pc.pop_front();
    got_inst = seen_inst.pop_front();
    checks++;
    assert (got_pc === pc) else begin
      $display("[ERROR] %s: pc expected %h actual %h", cur_name, pc, got_pc);
      count_error();
    end
    assert (got_inst === word[INST_W-1:0]) else begin
      $display("[ERROR] %s: inst expected %h actual %h", cur_name, word[INST_W-1:0], got_inst);
      count_error();
    end
  endtask

  task automatic mem_read(logic [63:0] addr, logic [63:0] data);
    int base;
    base = done_cnt;
    mem_valid = 1'b1;
    mem_addr = addr;
    step();
    mem_valid = 1'b0;
    while (done_cnt == base) step();
    checks++;
    assert (done_data === data) else begin
      $display("[ERROR] %s: load expected %h actual %h", cur_name, data, done_data);
      count_error();
    end
    step();
    assert (done_cnt == base + 1) else begin
      $display("%s: more than one mem_done pulse for a single read", cur_name);
      count_error();
    end
  endtask

  task automatic run_record(int i);
    case (kind_q[i])
      "L": begin
        ld_we = 1'b1;
        ld_addr = a_q[i];
        ld_wdata = b_q[i];
        step();
        ld_we = 1'b0;
      end
      "C": begin
        cfg_we = 1'b1;
        cfg_addr = a_q[i][1:0];
        cfg_wdata = b_q[i];
        step();
        cfg_we = 1'b0;
      end
      "T": begin
        close_test();
        tests++;
        cur_name = name_q[i];
        test_err = 0;
        checks = 0;
      end
      "E": expect_inst(a_q[i], b_q[i]);
      "M": mem_read(a_q[i], b_q[i]);
      "R": begin
        repeat (int'(a_q[i])) step();
        redirect = 1'b1;
        redirect_pc = b_q[i];
        step();
        redirect = 1'b0;
        // words from before the redirect are not expected
        seen_pc.delete();
        seen_inst.delete();
      end
      "S": begin
        stall = 1'b1;
        // long enough that the fetch in flight lands while stalled
        repeat ($urandom_range(20, 12)) step();
        stall = 1'b0;
      end
      default: begin
        $display("unknown record kind %s in stimulus file", kind_q[i]);
        errors++;
      end
    endcase
  endtask

  initial begin
    bit ok;
    int events;
    void'($urandom(32'h7a130a50));
    limit_set = 1'b0;
    rst_n = 1'b0;
    cfg_we = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    ld_we = 1'b0;
    ld_addr = '0;
    ld_wdata = '0;
    redirect = 1'b0;
    redirect_pc = '0;
    stall = 1'b0;
    mem_valid = 1'b0;
    mem_addr = '0;
    errors = 0;
    tests = 0;
    done_cnt = 0;
    cur_name = "setup";
    ok = read_records();
    if (!ok) begin
      $display("cannot open tests/fetch_input.txt");
      $display("Simulation failed");
      $finish;
    end else begin
      events = 0;
      foreach (kind_q[i]) begin
        if (kind_q[i] == "T") events += int'(a_q[i]);
      end
      limit = 40 * events + 16 + 2 * kind_q.size();
      limit_set = 1'b1;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      foreach (kind_q[i]) run_record(i);
      close_test();
      $display("tests %0d, errors %0d", tests, errors);
      if (errors == 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

// File: tests/fetch_input.txt
# L addr data = load, C reg data = config write, T name count = test start
# E pc inst = expected fetch, M addr data = load read, R cycles pc = redirect, S = stall
L 80 a1a1a1a1b0b0b0b0
L 88 a3a3a3a3b2b2b2b2
L 90 a5a5a5a5b4b4b4b4
L 98 a7a7a7a7b6b6b6b6
L 100 c1c1c1c1d0d0d0d0
L 108 e3e3e3e3e2e2e2e2
L 200 0123456789abcdef
C 2 0
C 0 80
C 1 1
T seq_wait0 4
E 80 b0b0b0b0
E 84 a1a1a1a1
E 88 b2b2b2b2
E 8c a3a3a3a3
T wait5_mem 3
C 2 5
E 90 b4b4b4b4
M 200 0123456789abcdef
E 94 a5a5a5a5
T redirect 2
R 3 100
E 100 d0d0d0d0
E 104 c1c1c1c1
T stall 2
S
E 108 e2e2e2e2
E 10c e3e3e3e3

// File: files.f
logic/fetch_pkg.sv
logic/axi_rd_pkg.sv
logic/fetch_ctrl_regs.sv
logic/pc_gen.sv
logic/rd_arbiter.sv
logic/axi_rd_master.sv
logic/axi_rd_mem.sv
logic/if_stage_top.sv
tests/if_stage_assert.sv
tests/tb_if_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_if_stage
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
